// ==== banked_sram.f ====
+incdir+rtl
rtl/sram_pkg.sv
rtl/bank_if.sv
rtl/bank_router.sv
rtl/sram_bank.sv
rtl/resp_merge.sv
rtl/banked_sram.sv
verif/banked_sram_tb.sv

// ==== rtl/bank_if.sv ====
// request and response channels between router, one bank and merger
// one instance per bank, both channels valid/ready
`timescale 1ns/100ps
`default_nettype none

interface bank_if;

	logic                 req_valid;
	logic                 req_ready;
	sram_pkg::bank_req_t  req;

	logic                 rsp_valid;
	logic                 rsp_ready;
	sram_pkg::bank_rsp_t  rsp;

	modport router (
		output req_valid, req,
		input  req_ready
	);

	modport bank (
		input  req_valid, req, rsp_ready,
		output req_ready, rsp_valid, rsp
	);

	modport merger (
		input  rsp_valid, rsp,
		output rsp_ready
	);

endinterface

`default_nettype wire

// ==== rtl/bank_router.sv ====
// takes one read or write from the slave port and sends it to its bank
// stays busy until the merger reports the response was taken
`timescale 1ns/100ps
`default_nettype none
`include "sram_defs.svh"

module bank_router (
	input  wire logic                  clk,
	input  wire logic                  rstn,
	input  wire logic [`ADDR_W-1:0]    araddr_i,
	input  wire logic                  arvalid_i,
	output logic                       arready_o,
	input  wire logic [`ADDR_W-1:0]    awaddr_i,
	input  wire logic                  awvalid_i,
	output logic                       awready_o,
	input  wire logic [`DATA_W-1:0]    wdata_i,
	input  wire logic [`DATA_W/8-1:0]  wstrb_i,
	input  wire logic                  wvalid_i,
	output logic                       wready_o,
	input  wire logic                  done_i,
	bank_if.router                     banks [`NUM_BANKS]
);

	localparam int BANK_W = $clog2(`NUM_BANKS);
	localparam int ROW_W  = sram_pkg::ROW_W;

	logic                  busy;
	logic [`NUM_BANKS-1:0] vld_q;   // one-hot, only the addressed bank
	logic [`NUM_BANKS-1:0] rdy_vec;
	sram_pkg::bank_req_t   req_q;
	logic                  rd_go;
	logic                  wr_go;
	logic [`ADDR_W-1:0]    addr;
	logic [BANK_W-1:0]     bidx;
	logic [ROW_W-1:0]      row;

	assign arready_o = rstn & ~busy; // closed during reset
	assign awready_o = arready_o & ~arvalid_i; // read wins a tie
	assign wready_o  = awready_o;

	assign rd_go = arvalid_i & arready_o;
	assign wr_go = awvalid_i & wvalid_i & awready_o;

	// word interleave, bank on the lowest word bits
	assign addr = rd_go ? araddr_i : awaddr_i;
	assign bidx = addr[BANK_W+1:2];
	assign row  = addr[BANK_W+ROW_W+1:BANK_W+2];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy  <= 1'b0;
			vld_q <= '0;
		end else if (!busy) begin
			if (rd_go || wr_go) begin
				busy  <= 1'b1;
				vld_q <= {{(`NUM_BANKS-1){1'b0}}, 1'b1} << bidx;
			end
		end else begin
			vld_q <= vld_q & ~rdy_vec; // drop once the bank took it
			if (done_i)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_go || wr_go)
			req_q <= '{write: ~rd_go, row: row, wdata: wdata_i, strb: wstrb_i};
	end

	for (genvar g = 0; g < `NUM_BANKS; g++) begin : g_bank
		assign banks[g].req_valid = vld_q[g];
		assign banks[g].req       = req_q;
		assign rdy_vec[g]         = banks[g].req_ready;
	end

endmodule

`default_nettype wire

// ==== rtl/banked_sram.sv ====
// banked SRAM behind an AXI-lite style slave port
// router feeds NUM_BANKS interleaved banks, merger returns the response
`timescale 1ns/100ps
`default_nettype none
`include "sram_defs.svh"

module banked_sram (
	input  wire logic                  clk,
	input  wire logic                  rstn,
	input  wire logic [`ADDR_W-1:0]    araddr_i,
	input  wire logic                  arvalid_i,
	output logic                       arready_o,
	output logic [`DATA_W-1:0]         rdata_o,
	output sram_pkg::resp_e            rresp_o,
	output logic                       rvalid_o,
	input  wire logic                  rready_i,
	input  wire logic [`ADDR_W-1:0]    awaddr_i,
	input  wire logic                  awvalid_i,
	output logic                       awready_o,
	input  wire logic [`DATA_W-1:0]    wdata_i,
	input  wire logic [`DATA_W/8-1:0]  wstrb_i,
	input  wire logic                  wvalid_i,
	output logic                       wready_o,
	output sram_pkg::resp_e            bresp_o,
	output logic                       bvalid_o,
	input  wire logic                  bready_i
);

	logic done;

	bank_if bif [`NUM_BANKS] ();

	bank_router u_router (
		.clk       (clk),
		.rstn      (rstn),
		.araddr_i  (araddr_i),
		.arvalid_i (arvalid_i),
		.arready_o (arready_o),
		.awaddr_i  (awaddr_i),
		.awvalid_i (awvalid_i),
		.awready_o (awready_o),
		.wdata_i   (wdata_i),
		.wstrb_i   (wstrb_i),
		.wvalid_i  (wvalid_i),
		.wready_o  (wready_o),
		.done_i    (done),
		.banks     (bif)
	);

	for (genvar g = 0; g < `NUM_BANKS; g++) begin : g_bank
		sram_bank u_bank (
			.clk  (clk),
			.rstn (rstn),
			.port (bif[g])
		);
	end

	resp_merge u_merge (
		.clk      (clk),
		.rstn     (rstn),
		.banks    (bif),
		.rdata_o  (rdata_o),
		.rresp_o  (rresp_o),
		.rvalid_o (rvalid_o),
		.rready_i (rready_i),
		.bresp_o  (bresp_o),
		.bvalid_o (bvalid_o),
		.bready_i (bready_i),
		.done_o   (done)
	);

endmodule

`default_nettype wire

// ==== rtl/resp_merge.sv ====
// picks the one bank holding a response and registers it onto r or b
// done_o marks the cycle the master takes it
`timescale 1ns/100ps
`default_nettype none
`include "sram_defs.svh"

module resp_merge (
	input  wire logic                clk,
	input  wire logic                rstn,
	bank_if.merger                   banks [`NUM_BANKS],
	output logic [`DATA_W-1:0]       rdata_o,
	output sram_pkg::resp_e          rresp_o,
	output logic                     rvalid_o,
	input  wire logic                rready_i,
	output sram_pkg::resp_e          bresp_o,
	output logic                     bvalid_o,
	input  wire logic                bready_i,
	output logic                     done_o
);

	logic [`NUM_BANKS-1:0] vld_vec;
	sram_pkg::bank_rsp_t   rsp_arr [`NUM_BANKS];
	sram_pkg::bank_rsp_t   sel;
	logic                  out_busy;
	logic                  take;
	logic [`DATA_W-1:0]    rdata_q;
	sram_pkg::resp_e       resp_q;

	assign out_busy = rvalid_o | bvalid_o;
	assign take     = (|vld_vec) & ~out_busy;

	for (genvar g = 0; g < `NUM_BANKS; g++) begin : g_bank
		assign vld_vec[g]         = banks[g].rsp_valid;
		assign rsp_arr[g]         = banks[g].rsp;
		assign banks[g].rsp_ready = banks[g].rsp_valid & ~out_busy;
	end

	// at most one bank is valid, so an OR of the masked payloads is enough
	always_comb begin
		sel = '0;
		for (int i = 0; i < `NUM_BANKS; i++) begin
			if (vld_vec[i])
				sel = sram_pkg::bank_rsp_t'(sel | rsp_arr[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			rvalid_o <= 1'b0;
			bvalid_o <= 1'b0;
		end else if (take) begin
			rvalid_o <= ~sel.write;
			bvalid_o <= sel.write;
		end else begin
			if (rready_i)
				rvalid_o <= 1'b0;
			if (bready_i)
				bvalid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			rdata_q <= sel.rdata;
			resp_q  <= sel.resp;
		end
	end

	assign rdata_o = rdata_q;
	assign rresp_o = resp_q;
	assign bresp_o = resp_q;
	assign done_o  = (rvalid_o & rready_i) | (bvalid_o & bready_i);

endmodule

`default_nettype wire

// ==== rtl/sram_bank.sv ====
// one SRAM bank: byte-strobed write, fixed access latency, held response
// serves a single request at a time through its bank_if
`timescale 1ns/100ps
`default_nettype none
`include "sram_defs.svh"

module sram_bank (
	input  wire logic  clk,
	input  wire logic  rstn,
	bank_if.bank       port
);

	localparam logic [3:0] LAT_CNT = `BANK_LAT;

	typedef enum logic [1:0] {
		WAIT_REQ = 2'd0,
		LATENCY  = 2'd1,
		RESPOND  = 2'd2
	} state_e;

	state_e              state;
	state_e              next_state;
	logic [3:0]          cnt;
	logic                accept;
	logic [`DATA_W-1:0]  mem [`BANK_ROWS];
	logic [`DATA_W-1:0]  rdata_q;
	logic                write_q;

	assign port.req_ready = (state == WAIT_REQ);
	assign accept         = port.req_valid & port.req_ready;

	assign port.rsp_valid = (state == RESPOND);
	assign port.rsp       = '{rdata: rdata_q, resp: sram_pkg::OKAY, write: write_q};

	always_comb begin
		next_state = state;
		case (state)
			WAIT_REQ: begin
				if (accept)
					next_state = (LAT_CNT == 4'd0) ? RESPOND : LATENCY;
			end
			LATENCY: begin
				if (cnt == LAT_CNT)
					next_state = RESPOND;
			end
			RESPOND: begin
				if (port.rsp_ready)
					next_state = WAIT_REQ;
			end
			default: next_state = WAIT_REQ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn)
			state <= WAIT_REQ;
		else
			state <= next_state;
	end

	// counts 1..LAT_CNT while in LATENCY
	always_ff @(posedge clk) begin
		if (!rstn)
			cnt <= 4'd0;
		else if (accept)
			cnt <= 4'd1;
		else if (state == LATENCY)
			cnt <= cnt + 4'd1;
	end

	// storage, one byte lane per strobe bit
	always_ff @(posedge clk) begin
		if (accept && port.req.write) begin
			for (int b = 0; b < `DATA_W/8; b++) begin
				if (port.req.strb[b])
					mem[port.req.row][b*8 +: 8] <= port.req.wdata[b*8 +: 8];
			end
		end
	end

	// response payload captured at accept
	always_ff @(posedge clk) begin
		if (accept) begin
			rdata_q <= mem[port.req.row]; // old word on a write, unused there
			write_q <= port.req.write;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sram_defs.svh ====
// global sizes for the banked SRAM
// include wherever an address, data or bank width is needed
`ifndef SRAM_DEFS_SVH
`define SRAM_DEFS_SVH

`define ADDR_W 32 // byte address
`define DATA_W 32 // strobe is DATA_W/8

// bank count must stay a power of two
`define NUM_BANKS 4

`define BANK_ROWS 64 // words per bank

// cycles between accept and response, 0..15
`define BANK_LAT 3

`endif

// ==== rtl/sram_pkg.sv ====
// types shared by the banked SRAM and its testbench
`default_nettype none
`include "sram_defs.svh"

package sram_pkg;

	localparam int ROW_W = $clog2(`BANK_ROWS); // row index width inside a bank

	typedef enum logic [1:0] {
		OKAY   = 2'd0,
		SLVERR = 2'd2 // reserved, never returned
	} resp_e;

	// request toward one bank
	typedef struct packed {
		logic                  write;
		logic [ROW_W-1:0]      row;
		logic [`DATA_W-1:0]    wdata;
		logic [`DATA_W/8-1:0]  strb;
	} bank_req_t;

	typedef struct packed {
		logic [`DATA_W-1:0] rdata;
		resp_e              resp;
		logic               write; // selects the b channel instead of r
	} bank_rsp_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compiles the banked SRAM testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 -f banked_sram.f \
	--top-module banked_sram_tb -o sim_banked_sram
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_banked_sram > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Test OK" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== verif/banked_sram_tb.sv ====
// random read/write traffic for the banked SRAM, checked against a memory model
// covers strobes, bank interleave, aliasing, latency, stalls and read priority
`timescale 1ns/100ps
`default_nettype none
`include "sram_defs.svh"

module banked_sram_tb;

	localparam int NUM_OPS     = 400;
	localparam int MAX_STALL   = 16;
	localparam int CYCLE_LIMIT = NUM_OPS * (`BANK_LAT + 3 + MAX_STALL) + 100;
	localparam int MODEL_WORDS = `NUM_BANKS * `BANK_ROWS; // wraps every 1 KiB
	localparam int RESP_LAT    = `BANK_LAT + 2; // handshake edge to valid edge

	logic                  clk;
	logic                  rstn;
	logic [`ADDR_W-1:0]    araddr;
	logic                  arvalid;
	logic                  arready;
	logic [`DATA_W-1:0]    rdata;
	sram_pkg::resp_e       rresp;
	logic                  rvalid;
	logic                  rready;
	logic [`ADDR_W-1:0]    awaddr;
	logic                  awvalid;
	logic                  awready;
	logic [`DATA_W-1:0]    wdata;
	logic [`DATA_W/8-1:0]  wstrb;
	logic                  wvalid;
	logic                  wready;
	sram_pkg::resp_e       bresp;
	logic                  bvalid;
	logic                  bready;

	logic [31:0]           lfsr = 32'hebaca405;
	int                    cyc = 0;
	int                    hs_cyc;
	logic [`DATA_W-1:0]    mem_m [MODEL_WORDS];
	logic [`DATA_W/8-1:0]  known [MODEL_WORDS]; // bytes written so far
	logic [`ADDR_W-1:0]    last_addr = '0;

	banked_sram dut0 (
		.clk       (clk),
		.rstn      (rstn),
		.araddr_i  (araddr),
		.arvalid_i (arvalid),
		.arready_o (arready),
		.rdata_o   (rdata),
		.rresp_o   (rresp),
		.rvalid_o  (rvalid),
		.rready_i  (rready),
		.awaddr_i  (awaddr),
		.awvalid_i (awvalid),
		.awready_o (awready),
		.wdata_i   (wdata),
		.wstrb_i   (wstrb),
		.wvalid_i  (wvalid),
		.wready_o  (wready),
		.bresp_o   (bresp),
		.bvalid_o  (bvalid),
		.bready_i  (bready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc == CYCLE_LIMIT) begin
			$display("timeout: no end of test after %0d cycles", CYCLE_LIMIT);
			stop_failed();
		end
	end

	task automatic stop_failed();
		$display("Test FAILED");
		$fatal(1, "simulation stopped after a failure");
	endtask

	task automatic value_error(input string msg);
		$display("ERR %0t: %s", $time, msg);
		stop_failed();
	endtask

	// 32-bit fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic int word_idx(input logic [`ADDR_W-1:0] a);
		return (a >> 2) & (MODEL_WORDS - 1);
	endfunction

	function automatic logic [`DATA_W-1:0] byte_mask(input logic [`DATA_W/8-1:0] k);
		logic [`DATA_W-1:0] m;
		for (int b = 0; b < `DATA_W/8; b++)
			m[b*8 +: 8] = {8{k[b]}};
		return m;
	endfunction

	function automatic logic [`ADDR_W-1:0] pick_addr();
		logic [31:0]        mode;
		logic [31:0]        hi;
		logic [31:0]        lo;
		logic [`ADDR_W-1:0] a;
		mode = rand_bits(2);
		hi   = rand_bits(22);
		case (mode[1:0])
			2'd0: a = last_addr + 4; // next word, next bank
			2'd1: a = {hi[21:0], last_addr[9:0]}; // alias of the last word
			2'd2: begin
				lo = rand_bits(8);
				a  = {hi[21:0], lo[7:0], 2'b00};
			end
			default: begin
				lo = rand_bits(5);
				a  = {hi[21:0], 3'b000, lo[4:0], 2'b00}; // small window, lots of reuse
			end
		endcase
		return a;
	endfunction

	task automatic model_write(input logic [`ADDR_W-1:0] a, input logic [`DATA_W-1:0] d,
			input logic [`DATA_W/8-1:0] s);
		int i;
		i = word_idx(a);
		for (int b = 0; b < `DATA_W/8; b++) begin
			if (s[b]) begin
				mem_m[i][b*8 +: 8] = d[b*8 +: 8];
				known[i][b]        = 1'b1;
			end
		end
	endtask

	task automatic check_read(input logic [`DATA_W-1:0] got, input sram_pkg::resp_e got_resp,
			input logic [`DATA_W-1:0] exp, input logic [`DATA_W-1:0] mask);
		if ((got & mask) !== (exp & mask))
			value_error($sformatf("read data %h, expected %h (mask %h)", got, exp, mask));
		if (got_resp !== sram_pkg::OKAY)
			value_error($sformatf("rresp %0d, expected OKAY", got_resp));
	endtask

	task automatic check_bresp(input sram_pkg::resp_e got, input sram_pkg::resp_e exp);
		if (got !== exp)
			value_error($sformatf("bresp %0d, expected %0d", got, exp));
	endtask

	task automatic check_cycles(input int got, input int exp, input string what);
		if (got != exp)
			value_error($sformatf("%s took %0d cycles, expected %0d", what, got, exp));
	endtask

	// call at a falling edge with the valids driven; returns after the handshake
	task automatic accept_req();
		while (!arready)
			@(negedge clk);
		@(negedge clk);
		hs_cyc = cyc;
	endtask

	task automatic take_resp(input bit is_read, input logic [`ADDR_W-1:0] addr);
		logic [`DATA_W-1:0] held;
		sram_pkg::resp_e    held_resp;
		int                 stall;
		int                 i;
		i = word_idx(addr);
		while (!(is_read ? rvalid : bvalid)) begin
			if (is_read ? bvalid : rvalid)
				value_error("response arrived on the wrong channel");
			@(negedge clk);
		end
		check_cycles(cyc - hs_cyc, RESP_LAT, "request to response");
		held      = rdata;
		held_resp = is_read ? rresp : bresp;
		stall     = rand_bits(4);
		repeat (stall) begin
			@(negedge clk);
			if (!(is_read ? rvalid : bvalid) || arready || awready || wready)
				value_error("valid dropped or port ready during a stall");
			if ((is_read && rdata !== held) || (is_read ? rresp : bresp) !== held_resp)
				value_error("response payload changed during a stall");
		end
		if (is_read)
			check_read(held, held_resp, mem_m[i], byte_mask(known[i]));
		else
			check_bresp(held_resp, sram_pkg::OKAY);
		rready = is_read;
		bready = !is_read;
		@(negedge clk);
		rready = 1'b0;
		bready = 1'b0;
		if (rvalid || bvalid || !arready || !awready || !wready)
			value_error("ready not back one cycle after the response handshake");
	endtask

	task automatic read_op(input logic [`ADDR_W-1:0] a);
		araddr  = a;
		arvalid = 1'b1;
		accept_req();
		arvalid = 1'b0;
		take_resp(1'b1, a);
	endtask

	task automatic write_op(input logic [`ADDR_W-1:0] a, input logic [`DATA_W-1:0] d,
			input logic [`DATA_W/8-1:0] s);
		awaddr  = a;
		wdata   = d;
		wstrb   = s;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		accept_req();
		awvalid = 1'b0;
		wvalid  = 1'b0;
		model_write(a, d, s);
		take_resp(1'b0, a);
	endtask

	initial begin
		int                   ops;
		logic [31:0]          r;
		logic [31:0]          hi;
		logic [`ADDR_W-1:0]   addr;
		logic [`ADDR_W-1:0]   alias_a;
		logic [`DATA_W-1:0]   data;
		logic [`DATA_W/8-1:0] strb;
		ops     = 0;
		rstn    = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		for (int i = 0; i < MODEL_WORDS; i++)
			known[i] = '0;
		repeat (4) @(negedge clk);
		if (arready || awready || wready || rvalid || bvalid)
			value_error("ready or valid high during reset");
		rstn = 1'b1;
		@(negedge clk);
		if (rvalid || bvalid || !arready || !awready || !wready)
			value_error("port not idle after reset");
		while (ops < NUM_OPS) begin
			r    = rand_bits(2);
			addr = pick_addr();
			data = rand_bits(`DATA_W);
			hi   = rand_bits(`DATA_W/8);
			strb = hi[`DATA_W/8-1:0];
			case (r[1:0])
				2'd0: begin
					// read and write together, read goes first and sees old data
					hi      = rand_bits(22);
					alias_a = {hi[21:0], addr[9:0]};
					araddr  = alias_a;
					arvalid = 1'b1;
					awaddr  = addr;
					wdata   = data;
					wstrb   = strb;
					awvalid = 1'b1;
					wvalid  = 1'b1;
					accept_req();
					arvalid = 1'b0;
					take_resp(1'b1, alias_a);
					accept_req();
					awvalid = 1'b0;
					wvalid  = 1'b0;
					model_write(addr, data, strb);
					take_resp(1'b0, addr);
					read_op(alias_a);
					ops += 3;
				end
				2'd1: begin
					write_op(addr, data, strb);
					ops += 1;
				end
				default: begin
					read_op(addr);
					ops += 1;
				end
			endcase
			last_addr = addr;
		end
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire
